//--- rtl/cache_defs.svh
`ifndef CACHE_DEFS_SVH
`define CACHE_DEFS_SVH

// address split of the low 16 bits of the byte address
`define CACHE_TAG_BITS 3
`define CACHE_INDEX_BITS 11

// one word per block
`define CACHE_BLOCKS 2048

// backing store size in 32-bit words
`define MEM_WORDS 16384

// cycles from a memory strobe to its ack, must be at least 2
`define MEM_LATENCY 4

`endif

//--- rtl/cache_pkg.sv
`default_nettype none

`include "cache_defs.svh"

package cache_pkg;

    // low half of the byte address
    typedef struct packed {
        logic [`CACHE_TAG_BITS-1:0]   tag;
        logic [`CACHE_INDEX_BITS-1:0] index;
        logic [1:0]                   byte_num;
    } cache_addr_t;

    // big-endian view, bytes[0] is the most significant byte
    typedef union packed {
        logic [31:0]     word;
        logic [0:3][7:0] bytes;
    } cache_word_u;

    typedef struct packed {
        logic        we;
        logic        is_word;
        logic [31:0] addr;
        logic [31:0] wdata;
    } cpu_req_t;

    typedef struct packed {
        logic        done;
        logic        hit;
        logic [31:0] rdata;
    } cpu_rsp_t;

    // controller to array
    typedef struct packed {
        logic        we_cache;
        logic        set_valid;
        logic        set_dirty;
        logic        is_word;
        logic [31:0] wdata;
    } array_ctl_t;

    // array to controller
    typedef struct packed {
        logic                       cache_hit;
        logic                       cache_dirty;
        cache_word_u                data_out;
        logic [`CACHE_TAG_BITS-1:0] victim_tag;
    } array_stat_t;

    typedef struct packed {
        logic        rd;
        logic        wr;
        logic [15:0] addr;
        logic [31:0] wdata;
    } mem_req_t;

    typedef struct packed {
        logic        ack;
        logic [31:0] rdata;
    } mem_rsp_t;

    typedef struct packed {
        logic [15:0] hits;
        logic [15:0] misses;
        logic [15:0] writebacks;
    } cache_stats_t;

endpackage

`default_nettype wire

//--- rtl/cache_array.sv
`default_nettype none

`include "cache_defs.svh"

module cache_array
    import cache_pkg::*;
(
    input  logic        clk,
    input  logic        arst_n,
    input  cache_addr_t addr,
    input  array_ctl_t  ctl,
    output array_stat_t stat
);

    cache_word_u                data_mem  [`CACHE_BLOCKS];
    logic [`CACHE_TAG_BITS-1:0] tag_mem   [`CACHE_BLOCKS];
    logic                       dirty_mem [`CACHE_BLOCKS];
    logic [`CACHE_BLOCKS-1:0]   valid_q;

    cache_word_u cur_word;
    cache_word_u merged;

    // combinational lookup of the addressed block
    always_comb begin
        cur_word = data_mem[addr.index];
    end

    assign stat.cache_hit   = valid_q[addr.index] && (tag_mem[addr.index] == addr.tag);
    // a dirty bit only counts on a valid block
    assign stat.cache_dirty = valid_q[addr.index] && dirty_mem[addr.index];
    assign stat.data_out    = cur_word;
    assign stat.victim_tag  = tag_mem[addr.index];

    // byte store drops the low byte of wdata into the selected lane
    always_comb begin
        merged = cur_word;
        merged.bytes[addr.byte_num] = ctl.wdata[7:0];
    end

    always_ff @(posedge clk) begin
        if (ctl.we_cache) begin
            if (ctl.is_word) begin
                data_mem[addr.index].word <= ctl.wdata;
            end else begin
                data_mem[addr.index].word <= merged.word;
            end
            tag_mem[addr.index]   <= addr.tag;
            dirty_mem[addr.index] <= ctl.set_dirty;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= '0;
        end else if (ctl.we_cache) begin
            valid_q[addr.index] <= ctl.set_valid;
        end
    end

    // a block can only turn dirty while it stays valid
    dirty_needs_valid: assert property (
        @(posedge clk) disable iff (!arst_n)
        ctl.we_cache |-> !(ctl.set_dirty && !ctl.set_valid)
    ) else $error("cache_array: set_dirty without set_valid");

    // byte merges only land on a resident block
    byte_write_on_hit: assert property (
        @(posedge clk) disable iff (!arst_n)
        (ctl.we_cache && !ctl.is_word) |-> stat.cache_hit
    ) else $error("cache_array: byte write to a block that misses");

endmodule

`default_nettype wire

//--- rtl/cache_controller.sv
`default_nettype none

`include "cache_defs.svh"

module cache_controller
    import cache_pkg::*;
(
    input  logic         clk,
    input  logic         arst_n,
    input  logic         req,
    input  cpu_req_t     cpu_req,
    output logic         busy,
    output cpu_rsp_t     cpu_rsp,
    output cache_stats_t stats,
    output array_ctl_t   ctl,
    output cache_addr_t  addr,
    input  array_stat_t  stat,
    output mem_req_t     mem_req,
    input  mem_rsp_t     mem_rsp
);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_LOOKUP,
        ST_WRITEBACK,
        ST_FILL,
        ST_FINISH
    } state_t;

    state_t state_q;
    state_t state_d;

    // set until the first lookup of an access is done
    logic first_q;
    // memory strobe already sent in the current phase
    logic issued_q;
    logic hit_q;

    // latched request
    logic        we_q;
    logic        is_word_q;
    cache_addr_t addr_q;
    logic [31:0] wdata_q;

    logic [31:0] rdata_q;
    logic [31:0] load_data;
    logic        mem_strobe;

    assign addr    = addr_q;
    assign busy    = (state_q != ST_IDLE);

    assign cpu_rsp.done  = (state_q == ST_FINISH);
    assign cpu_rsp.hit   = hit_q;
    assign cpu_rsp.rdata = rdata_q;

    // byte loads come back zero-extended
    always_comb begin
        if (is_word_q) begin
            load_data = stat.data_out.word;
        end else begin
            load_data = {24'b0, stat.data_out.bytes[addr_q.byte_num]};
        end
    end

    // one strobe at the start of each memory phase
    assign mem_req.wr    = (state_q == ST_WRITEBACK) && !issued_q;
    assign mem_req.rd    = (state_q == ST_FILL) && !issued_q;
    assign mem_req.wdata = stat.data_out.word;
    assign mem_strobe    = mem_req.rd || mem_req.wr;

    // victim goes back to its own address, fill uses the request tag
    always_comb begin
        if (state_q == ST_WRITEBACK) begin
            mem_req.addr = {stat.victim_tag, addr_q.index, 2'b00};
        end else begin
            mem_req.addr = {addr_q.tag, addr_q.index, 2'b00};
        end
    end

    always_comb begin
        ctl.we_cache  = 1'b0;
        ctl.set_valid = 1'b0;
        ctl.set_dirty = 1'b0;
        ctl.is_word   = 1'b1;
        ctl.wdata     = mem_rsp.rdata;
        case (state_q)
            ST_LOOKUP: begin
                if (stat.cache_hit && we_q) begin
                    ctl.we_cache  = 1'b1;
                    ctl.set_valid = 1'b1;
                    ctl.set_dirty = 1'b1;
                    ctl.is_word   = is_word_q;
                    ctl.wdata     = wdata_q;
                end
            end
            ST_WRITEBACK: begin
                // retire the victim once memory has it
                ctl.we_cache = mem_rsp.ack;
            end
            ST_FILL: begin
                ctl.we_cache  = mem_rsp.ack;
                ctl.set_valid = 1'b1;
            end
            default: begin
            end
        endcase
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if (req) begin
                    state_d = ST_LOOKUP;
                end
            end
            ST_LOOKUP: begin
                if (stat.cache_hit) begin
                    state_d = ST_FINISH;
                end else if (stat.cache_dirty) begin
                    state_d = ST_WRITEBACK;
                end else begin
                    state_d = ST_FILL;
                end
            end
            ST_WRITEBACK, ST_FILL: begin
                // replay the lookup after each memory phase
                if (mem_rsp.ack) begin
                    state_d = ST_LOOKUP;
                end
            end
            default: begin
                state_d = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q  <= ST_IDLE;
            first_q  <= 1'b0;
            issued_q <= 1'b0;
            hit_q    <= 1'b0;
            stats    <= '0;
        end else begin
            state_q <= state_d;
            if (mem_strobe) begin
                issued_q <= 1'b1;
            end else if (mem_rsp.ack) begin
                issued_q <= 1'b0;
            end
            if (state_q == ST_IDLE && req) begin
                first_q <= 1'b1;
            end else if (state_q == ST_LOOKUP) begin
                first_q <= 1'b0;
            end
            // replayed lookups are not counted
            if (state_q == ST_LOOKUP && first_q) begin
                hit_q <= stat.cache_hit;
                if (stat.cache_hit) begin
                    stats.hits <= stats.hits + 1'b1;
                end else begin
                    stats.misses <= stats.misses + 1'b1;
                end
            end
            if (state_q == ST_WRITEBACK && mem_rsp.ack) begin
                stats.writebacks <= stats.writebacks + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == ST_IDLE && req) begin
            we_q      <= cpu_req.we;
            is_word_q <= cpu_req.is_word;
            addr_q    <= cpu_req.addr[15:0];
            wdata_q   <= cpu_req.wdata;
        end
        if (state_q == ST_LOOKUP && stat.cache_hit && !we_q) begin
            rdata_q <= load_data;
        end
    end

    req_only_when_idle: assert property (
        @(posedge clk) disable iff (!arst_n)
        req |-> !busy
    ) else $error("cache_controller: req while busy");

    // memory answers every strobe after the fixed latency
    mem_ack_latency: assert property (
        @(posedge clk) disable iff (!arst_n)
        mem_strobe |-> ##`MEM_LATENCY mem_rsp.ack
    ) else $error("cache_controller: memory ack missing");

    // no ack without an operation in flight
    mem_ack_outstanding: assert property (
        @(posedge clk) disable iff (!arst_n)
        mem_rsp.ack |-> issued_q
    ) else $error("cache_controller: unexpected memory ack");

endmodule

`default_nettype wire

//--- rtl/main_memory.sv
`default_nettype none

`include "cache_defs.svh"

module main_memory
    import cache_pkg::*;
(
    input  logic     clk,
    input  logic     arst_n,
    input  mem_req_t mem_req,
    output mem_rsp_t mem_rsp
);

    localparam int WADDR_W = $clog2(`MEM_WORDS);
    localparam int CNT_W   = $clog2(`MEM_LATENCY);

    logic [31:0] mem [`MEM_WORDS];

    logic               pending_q;
    logic [CNT_W-1:0]   cnt_q;
    logic               ack_q;
    logic               wr_q;
    logic [WADDR_W-1:0] waddr_q;
    logic [31:0]        wdata_q;
    logic [31:0]        rdata_q;
    logic               strobe;
    logic               complete;

    // word i holds i on top and its inverse below
    initial begin
        for (int i = 0; i < `MEM_WORDS; i++) begin
            mem[i] = {i[15:0], ~i[15:0]};
        end
    end

    assign strobe   = mem_req.rd || mem_req.wr;
    assign complete = pending_q && (cnt_q == '0);

    assign mem_rsp.ack   = ack_q;
    assign mem_rsp.rdata = rdata_q;

    // ack is registered, so the count starts two short
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pending_q <= 1'b0;
            cnt_q     <= '0;
            ack_q     <= 1'b0;
        end else begin
            ack_q <= 1'b0;
            if (strobe) begin
                pending_q <= 1'b1;
                cnt_q     <= CNT_W'(`MEM_LATENCY - 2);
            end else if (complete) begin
                pending_q <= 1'b0;
                ack_q     <= 1'b1;
            end else if (pending_q) begin
                cnt_q <= cnt_q - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (strobe) begin
            wr_q    <= mem_req.wr;
            waddr_q <= mem_req.addr[WADDR_W+1:2];
            wdata_q <= mem_req.wdata;
        end
        if (complete) begin
            if (wr_q) begin
                mem[waddr_q] <= wdata_q;
            end else begin
                rdata_q <= mem[waddr_q];
            end
        end
    end

    rd_wr_exclusive: assert property (
        @(posedge clk) disable iff (!arst_n)
        !(mem_req.rd && mem_req.wr)
    ) else $error("main_memory: rd and wr together");

    no_overlap: assert property (
        @(posedge clk) disable iff (!arst_n)
        strobe |-> !pending_q
    ) else $error("main_memory: strobe while an operation is pending");

endmodule

`default_nettype wire

//--- rtl/cache_top.sv
`default_nettype none

module cache_top
    import cache_pkg::*;
(
    input  logic         clk,
    input  logic         arst_n,
    input  logic         req,
    input  cpu_req_t     cpu_req,
    output logic         busy,
    output cpu_rsp_t     cpu_rsp,
    output cache_stats_t stats
);

    array_ctl_t  ctl;
    cache_addr_t addr;
    array_stat_t stat;
    mem_req_t    mem_req;
    mem_rsp_t    mem_rsp;

    cache_controller u_cache_controller (
        .clk     (clk),
        .arst_n  (arst_n),
        .req     (req),
        .cpu_req (cpu_req),
        .busy    (busy),
        .cpu_rsp (cpu_rsp),
        .stats   (stats),
        .ctl     (ctl),
        .addr    (addr),
        .stat    (stat),
        .mem_req (mem_req),
        .mem_rsp (mem_rsp)
    );

    cache_array u_cache_array (
        .clk    (clk),
        .arst_n (arst_n),
        .addr   (addr),
        .ctl    (ctl),
        .stat   (stat)
    );

    main_memory u_main_memory (
        .clk     (clk),
        .arst_n  (arst_n),
        .mem_req (mem_req),
        .mem_rsp (mem_rsp)
    );

endmodule

`default_nettype wire

//--- testbench/cache_tb.sv
`default_nettype none

`include "cache_defs.svh"

module cache_tb
    import cache_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    // generous bound over a dirty miss
    localparam int TIMEOUT_CYCLES = 4 * `MEM_LATENCY + 40;
    localparam int RANDOM_OPS     = 400;

    logic         clk;
    logic         arst_n;
    logic         req;
    cpu_req_t     cpu_req;
    logic         busy;
    cpu_rsp_t     cpu_rsp;
    cache_stats_t stats;

    // processor view of the 16-bit space with one entry per byte
    logic [7:0]                 ref_mem      [0:4*`MEM_WORDS-1];
    logic [`CACHE_TAG_BITS-1:0] shadow_tag   [0:`CACHE_BLOCKS-1];
    logic                       shadow_valid [0:`CACHE_BLOCKS-1];
    logic                       shadow_dirty [0:`CACHE_BLOCKS-1];
    cache_stats_t               exp_stats;

    integer      seed;
    logic        last_hit;
    logic [31:0] last_rdata;
    int          req_count  = 0;
    int          done_count = 0;

    cache_top u_cache_top (
        .clk     (clk),
        .arst_n  (arst_n),
        .req     (req),
        .cpu_req (cpu_req),
        .busy    (busy),
        .cpu_rsp (cpu_rsp),
        .stats   (stats)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    always @(negedge clk) begin
        if (arst_n && cpu_rsp.done) begin
            done_count <= done_count + 1;
        end
    end

    task automatic report_failure(input string line);
        $display("%s", line);
        $display("Test FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        assert (got === expected) else
            report_failure($sformatf("FAIL at %0t ns: %s is %h, expected %h",
                                     $time, name, got, expected));
    endtask

    // word i holds i on top and ~i below
    // byte 0 is the top byte
    function automatic void init_reference();
        logic [15:0] v;
        for (int w = 0; w < `MEM_WORDS; w++) begin
            v = w[15:0];
            ref_mem[4*w]   = v[15:8];
            ref_mem[4*w+1] = v[7:0];
            ref_mem[4*w+2] = ~v[15:8];
            ref_mem[4*w+3] = ~v[7:0];
        end
        for (int b = 0; b < `CACHE_BLOCKS; b++) begin
            shadow_tag[b]   = '0;
            shadow_valid[b] = 1'b0;
            shadow_dirty[b] = 1'b0;
        end
        exp_stats = '0;
    endfunction

    function automatic logic [31:0] ref_word(input logic [15:0] a);
        return {ref_mem[{a[15:2], 2'b00}], ref_mem[{a[15:2], 2'b01}],
                ref_mem[{a[15:2], 2'b10}], ref_mem[{a[15:2], 2'b11}]};
    endfunction

    // updates the shadow and returns hit flag and load data
    function automatic void predict(input logic we, input logic is_word,
                                    input logic [15:0] a, input logic [31:0] wdata,
                                    output logic hit, output logic [31:0] rdata);
        logic [`CACHE_TAG_BITS-1:0]   t;
        logic [`CACHE_INDEX_BITS-1:0] idx;
        t   = a[15:13];
        idx = a[12:2];
        hit = shadow_valid[idx] && (shadow_tag[idx] == t);
        if (hit) begin
            exp_stats.hits = exp_stats.hits + 16'd1;
        end else begin
            exp_stats.misses = exp_stats.misses + 16'd1;
            if (shadow_valid[idx] && shadow_dirty[idx]) begin
                exp_stats.writebacks = exp_stats.writebacks + 16'd1;
            end
            shadow_tag[idx]   = t;
            shadow_valid[idx] = 1'b1;
            shadow_dirty[idx] = 1'b0;
        end
        if (we) begin
            if (is_word) begin
                ref_mem[{a[15:2], 2'b00}] = wdata[31:24];
                ref_mem[{a[15:2], 2'b01}] = wdata[23:16];
                ref_mem[{a[15:2], 2'b10}] = wdata[15:8];
                ref_mem[{a[15:2], 2'b11}] = wdata[7:0];
            end else begin
                ref_mem[a] = wdata[7:0];
            end
            shadow_dirty[idx] = 1'b1;
        end
        if (is_word) begin
            rdata = ref_word(a);
        end else begin
            rdata = {24'b0, ref_mem[a]};
        end
    endfunction

    task automatic run_access(input logic we, input logic is_word,
                              input logic [15:0] a, input logic [31:0] wdata);
        logic        exp_hit;
        logic [31:0] exp_rdata;
        logic        seen;
        int          waited;
        predict(we, is_word, a, wdata, exp_hit, exp_rdata);
        @(posedge clk);
        req             <= 1'b1;
        cpu_req.we      <= we;
        cpu_req.is_word <= is_word;
        cpu_req.addr    <= {16'h0, a};
        cpu_req.wdata   <= wdata;
        @(posedge clk);
        req       <= 1'b0;
        req_count = req_count + 1;
        seen      = 1'b0;
        waited    = 0;
        while (!seen && waited < TIMEOUT_CYCLES) begin
            @(negedge clk);
            waited = waited + 1;
            seen   = cpu_rsp.done;
        end
        if (!seen) begin
            report_failure($sformatf("no done within %0d cycles of the request to address %h",
                                     TIMEOUT_CYCLES, a));
        end
        last_hit   = cpu_rsp.hit;
        last_rdata = cpu_rsp.rdata;
        check_value("cpu_rsp.hit", {31'b0, cpu_rsp.hit}, {31'b0, exp_hit});
        if (!we) begin
            check_value("cpu_rsp.rdata", cpu_rsp.rdata, exp_rdata);
        end
        check_value("stats.hits", {16'b0, stats.hits}, {16'b0, exp_stats.hits});
        check_value("stats.misses", {16'b0, stats.misses}, {16'b0, exp_stats.misses});
        check_value("stats.writebacks", {16'b0, stats.writebacks},
                    {16'b0, exp_stats.writebacks});
    endtask

    done_inside_busy: assert property (
        @(posedge clk) disable iff (!arst_n)
        cpu_rsp.done |-> busy
    ) else report_failure("done pulsed while busy was low");

    // busy drops right after the done cycle
    done_then_idle: assert property (
        @(posedge clk) disable iff (!arst_n)
        cpu_rsp.done |=> !busy
    ) else report_failure("busy still high after done");

    busy_after_accept: assert property (
        @(posedge clk) disable iff (!arst_n)
        (req && !busy) |=> busy
    ) else report_failure("busy did not rise after an accepted request");

    initial begin
        logic [15:0] a0;
        logic [15:0] a1;
        logic [31:0] r;
        logic [31:0] wd;

        seed    = 98;
        req     <= 1'b0;
        cpu_req <= '0;
        arst_n  <= 1'b0;
        init_reference();

        repeat (2) @(posedge clk);
        arst_n <= 1'b1;
        @(negedge clk);

        // state right after reset and a cold miss
        check_value("busy", {31'b0, busy}, 32'h0);
        check_value("stats", {16'b0, stats[47:32]} | {16'b0, stats[31:16]} |
                    {16'b0, stats[15:0]}, 32'h0);
        a0 = 16'h0104;
        run_access(1'b0, 1'b1, a0, 32'h0);
        check_value("cpu_rsp.hit", {31'b0, last_hit}, 32'h0);
        check_value("cpu_rsp.rdata", last_rdata, {16'h0041, ~16'h0041});

        // same address again hits
        run_access(1'b0, 1'b1, a0, 32'h0);
        check_value("cpu_rsp.hit", {31'b0, last_hit}, 32'h1);
        check_value("stats.hits", {16'b0, stats.hits}, 32'h1);

        // one byte store per lane with junk above the low byte
        for (int lane = 0; lane < 4; lane++) begin
            wd = {24'hA5C3E1, 4'(lane + 1), 4'(lane + 1)};
            run_access(1'b1, 1'b0, {a0[15:2], 2'(lane)}, wd);
        end
        run_access(1'b0, 1'b1, a0, 32'h0);
        check_value("cpu_rsp.rdata", last_rdata, 32'h11223344);
        for (int lane = 0; lane < 4; lane++) begin
            run_access(1'b0, 1'b0, {a0[15:2], 2'(lane)}, 32'h0);
        end

        // conflicting tag forces the dirty block out
        a1 = a0 ^ 16'h2000;
        run_access(1'b0, 1'b1, a1, 32'h0);
        check_value("cpu_rsp.hit", {31'b0, last_hit}, 32'h0);
        check_value("stats.writebacks", {16'b0, stats.writebacks}, 32'h1);
        run_access(1'b0, 1'b1, a0, 32'h0);
        check_value("cpu_rsp.hit", {31'b0, last_hit}, 32'h0);
        check_value("cpu_rsp.rdata", last_rdata, 32'h11223344);

        // 4 tags over 8 blocks keeps conflicts frequent
        for (int n = 0; n < RANDOM_OPS; n++) begin
            r  = $random(seed);
            wd = $random(seed);
            a0 = {1'b0, r[1:0], 8'h10, r[4:2], r[6:5]};
            run_access(r[8], r[9], a0, wd);
        end

        // let the done counter settle
        repeat (2) @(negedge clk);
        check_value("done count", done_count, req_count);

        $display("Test OK");
        $finish;
    end

endmodule

`default_nettype wire

//--- project.f
+incdir+rtl
rtl/cache_pkg.sv
rtl/cache_array.sv
rtl/cache_controller.sv
rtl/main_memory.sv
rtl/cache_top.sv
testbench/cache_tb.sv

//--- run.sh
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -f project.f --top-module cache_tb -o Vcache_tb

./obj_dir/Vcache_tb | tee sim.log

if grep -q "^Test OK$" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
